/* compile.f */
src/cpuIsaPkg.sv
src/cpuCtrlPkg.sv
src/registerFile.sv
src/alu.sv
src/wordMemory.sv
src/dataPath.sv
src/controlSequencer.sv
src/cpuTop.sv
test/cpuTop_props.sv
test/cpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f compile.f -o cpuSim
./obj_dir/cpuSim > sim.log
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi

/* src/alu.sv */
`timescale 1ns/1ns

module alu
	import cpuIsaPkg::*, cpuCtrlPkg::*;
(
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input aluOp_t op,
	output logic [2*dataWidth-1:0] result
);

	logic [shamtWidth-1:0] shamt;
	logic [2*dataWidth-1:0] rorPair;
	logic [2*dataWidth-1:0] rolPair;
	logic [2*dataWidth-1:0] product;
	logic [dataWidth-1:0] word;

	assign shamt = b[shamtWidth-1:0];
	assign rorPair = {a, a} >> shamt;
	assign rolPair = {a, a} << shamt;
	assign product = $signed(a) * $signed(b); // full 64-bit signed

	always_comb begin
		word = '0;
		unique case (op)
			aluAdd: word = a + b;
			aluSub: word = a - b;
			aluAnd: word = a & b;
			aluOr: word = a | b;
			aluShr: word = a >> shamt;
			aluShra: word = $signed(a) >>> shamt;
			aluShl: word = a << shamt;
			aluRor: word = rorPair[dataWidth-1:0];
			aluRol: word = rolPair[2*dataWidth-1:dataWidth];
			aluNeg: word = -a;
			aluNot: word = ~a;
			default: word = '0; // mul takes the product path
		endcase
	end

	assign result = (op == aluMul) ? product : {{dataWidth{word[dataWidth-1]}}, word};

endmodule

/* src/controlSequencer.sv */
`timescale 1ns/1ns

module controlSequencer
	import cpuIsaPkg::*, cpuCtrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic req,
	output logic ack,
	input instrWord_t ir,
	output ctrlWord_t ctrl
);

	typedef enum logic [1:0] {
		stIdle,
		stFetch,
		stStep,
		stDone
	} seqState_t;

	seqState_t state;
	logic [stepWidth-1:0] stepCnt;
	logic lastStep;

	function automatic aluOp_t aluOpFor(input opcode_t op);
		unique case (op)
			opSub: return aluSub;
			opAnd, opAndi: return aluAnd;
			opOr, opOri: return aluOr;
			opShr: return aluShr;
			opShra: return aluShra;
			opShl: return aluShl;
			opRor: return aluRor;
			opRol: return aluRol;
			opNeg: return aluNeg;
			opNot: return aluNot;
			opMul: return aluMul;
			default: return aluAdd; // add, addi, ld/st address
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		lastStep = 1'b0;
		if (state == stFetch) begin
			ctrl.irIn = 1'b1;
		end else if (state == stStep) begin
			unique case (ir.r.opcode)
				opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol, opNeg, opNot,
				opAddi, opAndi, opOri, opMul, opLd, opSt: begin
					unique case (stepCnt)
						0: begin
							ctrl.busSrc = srcGpr; // rb, base rule applies for ld/st
							ctrl.gprSel = selRb;
							ctrl.yIn = 1'b1;
						end
						1: begin
							ctrl.busSrc = (ir.r.opcode inside {opAddi, opAndi, opOri, opLd, opSt})
								? srcConst : srcGpr;
							ctrl.gprSel = selRc;
							ctrl.zIn = 1'b1;
							ctrl.aluOp = aluOpFor(ir.r.opcode);
						end
						2: begin
							ctrl.busSrc = srcZLo;
							ctrl.gprSel = selRa;
							ctrl.gprIn = !(ir.r.opcode inside {opMul, opLd, opSt});
							ctrl.loIn = ir.r.opcode == opMul;
							ctrl.marIn = ir.r.opcode inside {opLd, opSt};
							lastStep = !(ir.r.opcode inside {opMul, opLd, opSt});
						end
						3: begin
							ctrl.gprSel = selRa;
							if (ir.r.opcode == opMul) begin
								ctrl.busSrc = srcZHi;
								ctrl.hiIn = 1'b1;
							end else if (ir.r.opcode == opSt) begin
								ctrl.busSrc = srcGpr;
								ctrl.memWrite = 1'b1;
							end else begin
								ctrl.mdrIn = 1'b1; // ld pulls RAM data
								ctrl.memRead = 1'b1;
							end
							lastStep = ir.r.opcode != opLd;
						end
						default: begin
							ctrl.busSrc = srcMdr;
							ctrl.gprSel = selRa;
							ctrl.gprIn = 1'b1;
							lastStep = 1'b1;
						end
					endcase
				end
				opBr: begin
					ctrl.busSrc = srcGpr;
					ctrl.conIn = 1'b1;
					lastStep = 1'b1;
				end
				opIn, opMfhi, opMflo: begin
					ctrl.busSrc = (ir.r.opcode == opIn) ? srcInPort
						: (ir.r.opcode == opMfhi) ? srcHi : srcLo;
					ctrl.gprIn = 1'b1;
					lastStep = 1'b1;
				end
				opOut: begin
					ctrl.busSrc = srcGpr;
					ctrl.outIn = 1'b1;
					lastStep = 1'b1;
				end
				default: lastStep = 1'b1; // unknown opcode, no effect
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			stepCnt <= '0;
		end else begin
			unique case (state)
				stIdle: if (req) state <= stFetch;
				stFetch: begin
					state <= stStep;
					stepCnt <= '0;
				end
				stStep: begin
					if (lastStep) state <= stDone;
					stepCnt <= stepCnt + 1'b1;
				end
				default: if (!req) state <= stIdle; // hold ack until req drops
			endcase
		end
	end

	assign ack = state == stDone;

endmodule

/* src/cpuCtrlPkg.sv */
package cpuCtrlPkg;

	localparam int busSrcWidth = 4;
	localparam int regSelWidth = 2;
	localparam int aluOpWidth = 4;
	localparam int stepWidth = 3;

	typedef enum logic [busSrcWidth-1:0] {
		srcNone,
		srcGpr,
		srcZLo,
		srcZHi,
		srcHi,
		srcLo,
		srcMdr,
		srcInPort,
		srcConst // sign-extended immediate
	} busSrc_t;

	typedef enum logic [regSelWidth-1:0] {
		selRa,
		selRb,
		selRc
	} regSel_t;

	typedef enum logic [aluOpWidth-1:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShr,
		aluShra,
		aluShl,
		aluRor,
		aluRol,
		aluNeg,
		aluNot,
		aluMul
	} aluOp_t;

	typedef struct packed {
		busSrc_t busSrc;
		regSel_t gprSel;
		logic gprIn;
		logic yIn;
		logic zIn;
		logic hiIn;
		logic loIn;
		logic marIn;
		logic mdrIn;
		logic memRead;
		logic memWrite;
		logic outIn;
		logic conIn;
		logic irIn;
		aluOp_t aluOp;
	} ctrlWord_t;

endpackage

/* src/cpuIsaPkg.sv */
package cpuIsaPkg;

	localparam int dataWidth = 32;
	localparam int regCount = 16;
	localparam int regIdxWidth = 4;
	localparam int memWords = 512;
	localparam int memAddrWidth = 9;
	localparam int constWidth = 19;
	localparam int opWidth = 5;
	localparam int shamtWidth = 5;
	localparam int condWidth = 2;
	localparam int rUnusedWidth = dataWidth - opWidth - 3 * regIdxWidth;

	// branch conditions, low two bits of rb
	localparam logic [condWidth-1:0] condZero = 2'd0;
	localparam logic [condWidth-1:0] condNonZero = 2'd1;
	localparam logic [condWidth-1:0] condPlus = 2'd2;
	localparam logic [condWidth-1:0] condMinus = 2'd3;

	typedef enum logic [opWidth-1:0] {
		opLd   = 5'd0,
		opSt   = 5'd2,
		opAdd  = 5'd3,
		opSub  = 5'd4,
		opAnd  = 5'd5,
		opOr   = 5'd6,
		opRor  = 5'd7,
		opRol  = 5'd8,
		opShr  = 5'd9,
		opShra = 5'd10,
		opShl  = 5'd11,
		opAddi = 5'd12,
		opAndi = 5'd13,
		opOri  = 5'd14,
		opMul  = 5'd16,
		opNeg  = 5'd17,
		opNot  = 5'd18,
		opBr   = 5'd19,
		opIn   = 5'd22,
		opOut  = 5'd23,
		opMfhi = 5'd24,
		opMflo = 5'd25
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [regIdxWidth-1:0] ra;
		logic [regIdxWidth-1:0] rb;
		logic [regIdxWidth-1:0] rc;
		logic [rUnusedWidth-1:0] unused;
	} rFormat_t;

	typedef struct packed {
		opcode_t opcode;
		logic [regIdxWidth-1:0] ra;
		logic [regIdxWidth-1:0] rb;
		logic [constWidth-1:0] constVal;
	} iFormat_t;

	typedef union packed {
		rFormat_t r; // alu register ops
		iFormat_t i; // immediates, memory, branch
	} instrWord_t;

endpackage

/* src/cpuTop.sv */
`timescale 1ns/1ns

module cpuTop
	import cpuIsaPkg::*, cpuCtrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic req,
	input instrWord_t instrIn,
	output logic ack,
	input logic inStrobe,
	input logic [dataWidth-1:0] inData,
	output logic [dataWidth-1:0] outData,
	output logic conFlag
);

	ctrlWord_t ctrlWord;
	instrWord_t irWord;

	controlSequencer sequencer (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.ack(ack),
		.ir(irWord),
		.ctrl(ctrlWord)
	);

	dataPath datapath (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrlWord),
		.instrIn(instrIn),
		.ir(irWord),
		.inStrobe(inStrobe),
		.inData(inData),
		.outData(outData),
		.conFlag(conFlag)
	);

endmodule

/* src/dataPath.sv */
`timescale 1ns/1ns

module dataPath
	import cpuIsaPkg::*, cpuCtrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input ctrlWord_t ctrl,
	input instrWord_t instrIn,
	output instrWord_t ir,
	input logic inStrobe,
	input logic [dataWidth-1:0] inData,
	output logic [dataWidth-1:0] outData,
	output logic conFlag
);

	logic [dataWidth-1:0] bus;
	logic [dataWidth-1:0] gprData;
	logic [dataWidth-1:0] constExt;
	logic [dataWidth-1:0] yReg;
	logic [2*dataWidth-1:0] zReg;
	logic [2*dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] hiReg;
	logic [dataWidth-1:0] loReg;
	logic [memAddrWidth-1:0] marReg;
	logic [memAddrWidth-1:0] memAddr;
	logic [dataWidth-1:0] mdrReg;
	logic [dataWidth-1:0] memData;
	logic [dataWidth-1:0] inPortReg;
	logic baseAddr;
	logic condMet;

	assign constExt = {{(dataWidth - constWidth){ir.i.constVal[constWidth-1]}}, ir.i.constVal};
	assign baseAddr = (ir.i.opcode inside {opLd, opSt}) && ctrl.gprSel == selRb;

	always_comb begin
		unique case (ctrl.busSrc)
			srcGpr: bus = gprData;
			srcZLo: bus = zReg[dataWidth-1:0];
			srcZHi: bus = zReg[2*dataWidth-1:dataWidth];
			srcHi: bus = hiReg;
			srcLo: bus = loReg;
			srcMdr: bus = mdrReg;
			srcInPort: bus = inPortReg;
			srcConst: bus = constExt;
			default: bus = '0; // idle bus
		endcase
	end

	registerFile gprs (
		.clk(clk),
		.rstN(rstN),
		.ir(ir),
		.regSel(ctrl.gprSel),
		.wrEn(ctrl.gprIn),
		.baseAddr(baseAddr),
		.busIn(bus),
		.rdData(gprData)
	);

	alu aluUnit (
		.a(yReg),
		.b(bus),
		.op(ctrl.aluOp),
		.result(aluResult)
	);

	// address reaches the RAM as MAR loads, so read data is ready a step later
	assign memAddr = ctrl.marIn ? bus[memAddrWidth-1:0] : marReg;

	wordMemory ram (
		.clk(clk),
		.addr(memAddr),
		.wrData(bus),
		.wrEn(ctrl.memWrite),
		.rdData(memData)
	);

	always_comb begin
		unique case (ir.i.rb[condWidth-1:0])
			condZero: condMet = bus == '0;
			condNonZero: condMet = bus != '0;
			condPlus: condMet = !bus[dataWidth-1];
			default: condMet = bus[dataWidth-1]; // minus
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ir <= '0;
			yReg <= '0;
			zReg <= '0;
			hiReg <= '0;
			loReg <= '0;
			marReg <= '0;
			mdrReg <= '0;
			inPortReg <= '0;
			outData <= '0;
			conFlag <= 1'b0;
		end else begin
			if (ctrl.irIn) ir <= instrIn;
			if (ctrl.yIn) yReg <= bus;
			if (ctrl.zIn) zReg <= aluResult;
			if (ctrl.hiIn) hiReg <= bus;
			if (ctrl.loIn) loReg <= bus;
			if (ctrl.marIn) marReg <= bus[memAddrWidth-1:0];
			if (ctrl.mdrIn) mdrReg <= ctrl.memRead ? memData : bus;
			if (inStrobe) inPortReg <= inData; // free-running strobe
			if (ctrl.outIn) outData <= bus;
			if (ctrl.conIn) conFlag <= condMet;
		end
	end

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ns

module registerFile
	import cpuIsaPkg::*, cpuCtrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input instrWord_t ir,
	input regSel_t regSel,
	input logic wrEn,
	input logic baseAddr,
	input logic [dataWidth-1:0] busIn,
	output logic [dataWidth-1:0] rdData
);

	logic [dataWidth-1:0] regs [regCount];
	logic [regIdxWidth-1:0] regIdx;
	logic [regCount-1:0] wrSel;

	// pick the field, ra/rb/rc sit at the same bits in both formats
	always_comb begin
		unique case (regSel)
			selRa: regIdx = ir.r.ra;
			selRb: regIdx = ir.r.rb;
			default: regIdx = ir.r.rc;
		endcase
	end

	// one-hot write decode
	assign wrSel = wrEn ? (regCount'(1) << regIdx) : '0;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int k = 0; k < regCount; k++) begin
				regs[k] <= '0;
			end
		end else begin
			for (int k = 0; k < regCount; k++) begin
				if (wrSel[k]) begin
					regs[k] <= busIn;
				end
			end
		end
	end

	// R0 reads as zero only when used as a base
	assign rdData = (baseAddr && regIdx == '0) ? '0 : regs[regIdx];

endmodule

/* src/wordMemory.sv */
`timescale 1ns/1ns

module wordMemory
	import cpuIsaPkg::*;
(
	input logic clk,
	input logic [memAddrWidth-1:0] addr,
	input logic [dataWidth-1:0] wrData,
	input logic wrEn,
	output logic [dataWidth-1:0] rdData
);

	logic [dataWidth-1:0] mem [memWords];

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[addr] <= wrData;
		end
		rdData <= mem[addr]; // old data on a write cycle
	end

endmodule

/* test/cpuTb.sv */
`timescale 1ns/1ns

module cpuTb
	import cpuIsaPkg::*;
();

	localparam int resetCycles = 16;
	localparam int ioRuns = 200;
	localparam int aluRuns = 300;
	localparam int immRuns = 200;
	localparam int mulRuns = 50;
	localparam int memRuns = 100;
	localparam int brRuns = 100;
	localparam int plannedInstrs = ioRuns * 2 + aluRuns * 3 + immRuns * 3 + mulRuns * 7
		+ memRuns * 5 + brRuns * 2;
	localparam int cycleLimit = 60 * plannedInstrs + resetCycles;
	localparam logic [31:0] seed = 32'he39c_53ea;

	logic clk;
	logic rstN;
	logic req;
	instrWord_t instrIn;
	logic ack;
	logic inStrobe;
	logic [dataWidth-1:0] inData;
	logic [dataWidth-1:0] outData;
	logic conFlag;

	logic [dataWidth-1:0] regModel [regCount];
	logic [dataWidth-1:0] memModel [int];
	logic [dataWidth-1:0] hiModel;
	logic [dataWidth-1:0] loModel;
	logic [dataWidth-1:0] inModel;
	logic conModel;
	int errorCount;
	int checkCount;
	int cycleCount;

	cpuTop uut (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.instrIn(instrIn),
		.ack(ack),
		.inStrobe(inStrobe),
		.inData(inData),
		.outData(outData),
		.conFlag(conFlag)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic instrWord_t rWord(opcode_t op, logic [3:0] ra, logic [3:0] rb,
		logic [3:0] rc);
		instrWord_t w;
		w.r.opcode = op;
		w.r.ra = ra;
		w.r.rb = rb;
		w.r.rc = rc;
		w.r.unused = rUnusedWidth'($urandom); // ignored by decode
		return w;
	endfunction

	function automatic instrWord_t iWord(opcode_t op, logic [3:0] ra, logic [3:0] rb,
		logic [constWidth-1:0] c);
		instrWord_t w;
		w.i.opcode = op;
		w.i.ra = ra;
		w.i.rb = rb;
		w.i.constVal = c;
		return w;
	endfunction

	function automatic logic [dataWidth-1:0] signExtend(logic [constWidth-1:0] c);
		return {{(dataWidth - constWidth){c[constWidth-1]}}, c};
	endfunction

	function automatic opcode_t pickRegOp(int k);
		case (k)
			0: return opAdd;
			1: return opSub;
			2: return opAnd;
			3: return opOr;
			4: return opShr;
			5: return opShra;
			6: return opShl;
			7: return opRor;
			8: return opRol;
			9: return opNeg;
			default: return opNot;
		endcase
	endfunction

	// reference results straight from the instruction rules
	function automatic logic [dataWidth-1:0] expectAlu(opcode_t op, logic [31:0] a,
		logic [31:0] b);
		int s;
		s = int'(b[4:0]);
		case (op)
			opAdd, opAddi: return a + b;
			opSub: return a - b;
			opAnd, opAndi: return a & b;
			opOr, opOri: return a | b;
			opShr: return a >> s;
			opShra: return $signed(a) >>> s;
			opShl: return a << s;
			opRor: return (s == 0) ? a : (a >> s) | (a << (32 - s));
			opRol: return (s == 0) ? a : (a << s) | (a >> (32 - s));
			opNeg: return 32'd0 - a;
			opNot: return ~a;
			default: return '0;
		endcase
	endfunction

	function automatic logic expectCond(logic [1:0] cond, logic [31:0] v);
		case (cond)
			2'd0: return v == 32'd0;
			2'd1: return v != 32'd0;
			2'd2: return !v[31];
			default: return v[31];
		endcase
	endfunction

	function automatic logic [3:0] randReg();
		return 4'($urandom_range(0, regCount - 1));
	endfunction

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic waitAck(logic level);
		@(negedge clk);
		while (ack !== level) @(negedge clk);
	endtask

	// full four-phase handshake for one instruction
	task automatic issue(instrWord_t w);
		@(posedge clk);
		instrIn <= w;
		req <= 1'b1;
		waitAck(1'b1);
		@(posedge clk);
		req <= 1'b0;
		waitAck(1'b0);
	endtask

	task automatic strobeInput(logic [31:0] v);
		@(posedge clk);
		inStrobe <= 1'b1;
		inData <= v;
		@(posedge clk);
		inStrobe <= 1'b0;
		inModel = v;
	endtask

	task automatic loadReg(logic [3:0] idx, logic [31:0] v);
		strobeInput(v);
		issue(iWord(opIn, idx, 4'd0, '0));
		regModel[idx] = inModel;
	endtask

	task automatic outAndCheck(logic [3:0] idx);
		issue(iWord(opOut, idx, 4'd0, '0));
		checkValue("outData", outData, regModel[idx]);
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", cycleLimit);
		$display("checks run: %0d, errors: %0d", checkCount, errorCount);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [31:0] v;
		logic [31:0] addr;
		logic [constWidth-1:0] c;
		logic [1:0] cond;
		opcode_t op;
		longint prod;
		void'($urandom(seed));
		rstN = 1'b0;
		req = 1'b0;
		instrIn = '0;
		inStrobe = 1'b0;
		inData = '0;
		errorCount = 0;
		checkCount = 0;
		hiModel = '0;
		loModel = '0;
		inModel = '0;
		conModel = 1'b0;
		for (int k = 0; k < regCount; k++) regModel[k] = '0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkValue("ack", 32'(ack), 32'd0);
		checkValue("outData", outData, 32'd0);
		checkValue("conFlag", 32'(conFlag), 32'd0);

		for (int n = 0; n < ioRuns; n++) begin // input port to output port
			v = $urandom;
			ra = randReg();
			loadReg(ra, v);
			issue(iWord(opOut, ra, 4'd0, '0));
			checkValue("outData", outData, v);
		end

		for (int n = 0; n < aluRuns; n++) begin
			loadReg(randReg(), $urandom);
			op = pickRegOp($urandom_range(0, 10));
			ra = randReg();
			rb = randReg();
			rc = randReg();
			issue(rWord(op, ra, rb, rc));
			regModel[ra] = expectAlu(op, regModel[rb], regModel[rc]);
			outAndCheck(ra);
		end

		for (int n = 0; n < immRuns; n++) begin
			rb = randReg();
			loadReg(rb, $urandom);
			case ($urandom_range(0, 2))
				0: op = opAddi;
				1: op = opAndi;
				default: op = opOri;
			endcase
			ra = randReg();
			c = constWidth'($urandom);
			issue(iWord(op, ra, rb, c));
			regModel[ra] = expectAlu(op, regModel[rb], signExtend(c));
			outAndCheck(ra);
		end

		for (int n = 0; n < mulRuns; n++) begin
			rb = randReg();
			rc = randReg();
			loadReg(rb, $urandom);
			loadReg(rc, $urandom);
			issue(rWord(opMul, randReg(), rb, rc));
			prod = longint'(int'(regModel[rb])) * longint'(int'(regModel[rc]));
			loModel = prod[31:0];
			hiModel = prod[63:32];
			ra = randReg();
			issue(iWord(opMflo, ra, 4'd0, '0));
			regModel[ra] = loModel;
			outAndCheck(ra);
			ra = randReg();
			issue(iWord(opMfhi, ra, 4'd0, '0));
			regModel[ra] = hiModel;
			outAndCheck(ra);
		end

		for (int n = 0; n < memRuns; n++) begin
			rb = ($urandom_range(0, 3) == 0) ? 4'd0 : 4'($urandom_range(1, regCount - 1));
			ra = randReg();
			while (ra == rb) ra = randReg();
			if (rb != 4'd0) loadReg(rb, $urandom);
			loadReg(ra, $urandom);
			c = constWidth'($urandom);
			addr = ((rb == 4'd0) ? 32'd0 : regModel[rb]) + signExtend(c); // R0 base is zero
			issue(iWord(opSt, ra, rb, c));
			memModel[int'(addr[memAddrWidth-1:0])] = regModel[ra];
			rc = randReg();
			while (rc == ra) rc = randReg();
			issue(iWord(opLd, rc, rb, c));
			regModel[rc] = memModel[int'(addr[memAddrWidth-1:0])];
			outAndCheck(rc);
		end

		for (int n = 0; n < brRuns; n++) begin
			ra = randReg();
			loadReg(ra, ($urandom_range(0, 3) == 0) ? 32'd0 : $urandom);
			cond = 2'($urandom_range(0, 3));
			rb = {2'($urandom), cond}; // condition sits in the low bits of rb
			issue(iWord(opBr, ra, rb, constWidth'($urandom)));
			conModel = expectCond(cond, regModel[ra]);
			checkValue("conFlag", 32'(conFlag), 32'(conModel));
		end

		$display("checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* test/cpuTop_props.sv */
`timescale 1ns/1ns

module cpuTopProps
	import cpuIsaPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic req,
	input logic ack,
	input instrWord_t instrIn
);

	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> req)
		else $error("ack rose while req was low");

	ackHeld: assert property (@(posedge clk) disable iff (!rstN) ack && req |=> ack)
		else $error("ack dropped before req fell");

	instrStable: assert property (@(posedge clk) disable iff (!rstN)
		req && $past(req) |-> $stable(instrIn))
		else $error("instrIn changed while req was high");

	ackLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !ack)
		else $error("ack high at the end of reset");

endmodule

bind cpuTop cpuTopProps props (
	.clk(clk),
	.rstN(rstN),
	.req(req),
	.ack(ack),
	.instrIn(instrIn)
);
